// ==== compile.f ====
+incdir+rtl
rtl/bus_types_pkg.sv
rtl/cache_types_pkg.sv
rtl/cache_line_ram.sv
rtl/cache_controller.sv
rtl/main_memory.sv
rtl/cache_subsystem.sv
testbench/cache_assertions.sv
testbench/cache_subsystem_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with verilator, run it, look for the pass line
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module cache_subsystem_tb \
  && ./obj_dir/Vcache_subsystem_tb | tee /dev/stderr | grep -q "STATUS: PASS" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== testbench/cache_subsystem_tb.sv ====
//##########################################################
// directed request table for the cache subsystem, then a random
// read/write mix checked against a word-level memory model
//##########################################################
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_subsystem_tb;

  localparam int CLK_HALF       = 50;   // 100 ns period
  localparam int DRIVE_DELAY    = 5;    // inputs move just after the edge
  localparam int RESET_CYCLES   = 10;
  localparam int IDLE_CYCLES    = 5;    // quiet cycles watched after reset
  localparam int TABLE_LEN      = 21;
  localparam int RANDOM_REQS    = 200;
  localparam int CYCLES_PER_REQ = 40;   // worst case dirty miss takes about 36
  localparam int TIMEOUT_CYCLES =
    (TABLE_LEN + RANDOM_REQS) * CYCLES_PER_REQ + RESET_CYCLES + IDLE_CYCLES;

  // one directed request and its expected answer
  typedef struct packed {
    logic                 we;
    bus_types_pkg::addr_t addr;
    bus_types_pkg::word_t wdata;
    bus_types_pkg::word_t exp_data;  // reads only
    logic                 exp_hit;   // ready one cycle after sampling
  } stim_t;

  logic                 clk;
  logic                 rst;
  logic                 cpu_valid;
  logic                 cpu_we;
  bus_types_pkg::addr_t cpu_addr;
  bus_types_pkg::word_t cpu_wdata;
  logic                 cpu_ready;
  bus_types_pkg::word_t cpu_rdata;

  bus_types_pkg::word_t model [`MEM_WORDS];  // expected memory image
  int                   cycle_count = 0;

  // init pattern is address ^ 16'h5a00
  stim_t stim_table [TABLE_LEN] = '{
    '{1'b0, 12'h010, 16'h0000, 16'h5a10, 1'b0},  // cold miss at index 4 tag 0
    '{1'b0, 12'h011, 16'h0000, 16'h5a11, 1'b1},  // same line
    '{1'b0, 12'h013, 16'h0000, 16'h5a13, 1'b1},
    '{1'b0, 12'h010, 16'h0000, 16'h5a10, 1'b1},
    '{1'b1, 12'h012, 16'h1234, 16'h0000, 1'b1},  // write hit makes line dirty
    '{1'b0, 12'h012, 16'h0000, 16'h1234, 1'b1},
    '{1'b0, 12'h011, 16'h0000, 16'h5a11, 1'b1},  // neighbours untouched
    '{1'b0, 12'h013, 16'h0000, 16'h5a13, 1'b1},
    '{1'b1, 12'h025, 16'hbeef, 16'h0000, 1'b0},  // write miss on cold index 1
    '{1'b0, 12'h025, 16'h0000, 16'hbeef, 1'b1},
    '{1'b0, 12'h024, 16'h0000, 16'h5a24, 1'b1},
    '{1'b0, 12'h026, 16'h0000, 16'h5a26, 1'b1},
    '{1'b1, 12'h011, 16'ha5a5, 16'h0000, 1'b1},
    '{1'b0, 12'h031, 16'h0000, 16'h5a31, 1'b0},  // index 4 tag 1 evicts dirty A
    '{1'b0, 12'h012, 16'h0000, 16'h1234, 1'b0},  // A back from memory
    '{1'b0, 12'h011, 16'h0000, 16'ha5a5, 1'b1},
    '{1'b0, 12'h031, 16'h0000, 16'h5a31, 1'b0},  // clean victim this time
    '{1'b1, 12'h0a6, 16'h0f0f, 16'h0000, 1'b0},  // write miss over dirty index 1
    '{1'b0, 12'h025, 16'h0000, 16'hbeef, 1'b0},
    '{1'b0, 12'h0a6, 16'h0000, 16'h0f0f, 1'b0},
    '{1'b0, 12'hfff, 16'h0000, 16'h55ff, 1'b0}   // top of memory
  };

  cache_subsystem cache_subsystem_inst (
    .clk      (clk),
    .rst      (rst),
    .cpu_valid(cpu_valid),
    .cpu_we   (cpu_we),
    .cpu_addr (cpu_addr),
    .cpu_wdata(cpu_wdata),
    .cpu_ready(cpu_ready),
    .cpu_rdata(cpu_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // hang guard
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: no answer from the cache within %0d cycles, the run hung",
               TIMEOUT_CYCLES);
      $display("STATUS: FAIL");
      $fatal(1, "simulation hung");
    end
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
      $display("STATUS: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // holds one request until ready and counts latency from the sampling edge
  task automatic do_request(
    input  logic                 we,
    input  bus_types_pkg::addr_t addr,
    input  bus_types_pkg::word_t wdata,
    output bus_types_pkg::word_t rdata,
    output int                   latency
  );
    @(posedge clk);
    #DRIVE_DELAY;
    cpu_valid = 1'b1;
    cpu_we    = we;
    cpu_addr  = addr;
    cpu_wdata = wdata;
    @(posedge clk);  // DUT samples here
    latency = 0;
    do begin
      @(negedge clk);  // mid-cycle where outputs are settled
      latency++;
    end while (cpu_ready !== 1'b1);
    rdata = cpu_rdata;
    if (we) begin
      model[addr] = wdata;
    end
  endtask

  initial begin
    bus_types_pkg::word_t rdata;
    bus_types_pkg::addr_t addr;
    bus_types_pkg::word_t wdata;
    logic                 we;
    int                   latency;
    int                   tag_sel;

    void'($urandom(32'h4f1f4f01));
    rst       = 1'b1;
    cpu_valid = 1'b0;
    cpu_we    = 1'b0;
    cpu_addr  = '0;
    cpu_wdata = '0;
    for (int i = 0; i < `MEM_WORDS; i++) begin
      model[i] = bus_types_pkg::word_t'(i) ^ 16'h5a00;  // memory start pattern
    end

    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(posedge clk);
      #DRIVE_DELAY;
      check_value(cpu_ready, 1'b0, "cpu_ready during reset");
    end
    rst = 1'b0;
    repeat (IDLE_CYCLES) begin
      @(negedge clk);
      check_value(cpu_ready, 1'b0, "cpu_ready with no request");
    end

    // directed phase
    for (int i = 0; i < TABLE_LEN; i++) begin
      do_request(stim_table[i].we, stim_table[i].addr, stim_table[i].wdata, rdata, latency);
      if (!stim_table[i].we) begin
        check_value(rdata, stim_table[i].exp_data,
                    $sformatf("table entry %0d read of %h", i, stim_table[i].addr));
        check_value(rdata, model[stim_table[i].addr],
                    $sformatf("table entry %0d model read of %h", i, stim_table[i].addr));
      end
      check_value(latency == 1, stim_table[i].exp_hit,
                  $sformatf("table entry %0d one-cycle hit", i));
    end

    // random phase with 4 tags per index so lines keep evicting each other
    for (int n = 0; n < RANDOM_REQS; n++) begin
      tag_sel = $urandom_range(0, 3);
      addr    = bus_types_pkg::addr_t'(((tag_sel * 33) << 5) | $urandom_range(0, 31));
      we      = $urandom_range(0, 1);
      wdata   = bus_types_pkg::word_t'($urandom);
      do_request(we, addr, wdata, rdata, latency);
      if (!we) begin
        check_value(rdata, model[addr], $sformatf("random read %0d of %h", n, addr));
      end
    end

    @(posedge clk);
    #DRIVE_DELAY;
    cpu_valid = 1'b0;
    repeat (2) @(posedge clk);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== testbench/cache_assertions.sv ====
//##########################################################
// protocol checks on the cache controller, bound into every
// cache_controller instance so they watch its internal state
//##########################################################
`timescale 1ns/1ps

module cache_assertions (
  input logic                         clk,
  input logic                         rst,
  input cache_types_pkg::ctrl_state_t state,
  input logic                         cpu_ready,
  input logic                         wb_cyc,
  input logic                         wb_stb,
  input logic                         wb_we,
  input bus_types_pkg::addr_t         wb_adr,
  input bus_types_pkg::word_t         wb_dat_w,
  input logic                         wb_ack
);

  // strobe only inside a bus cycle
  stb_in_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc)
    else $error("wb_stb high without wb_cyc");

  // master holds the beat until the slave acks
  beat_held: assert property (@(posedge clk) disable iff (rst)
    wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_w))
    else $error("wishbone fields changed before ack");

  // answers come from the lookup state only
  ready_in_compare: assert property (@(posedge clk) disable iff (rst)
    cpu_ready |-> state == cache_types_pkg::compare_tag)
    else $error("cpu_ready outside compare_tag");

  // quiet port and bus right after reset
  quiet_after_reset: assert property (@(posedge clk) rst |=> !cpu_ready && !wb_cyc)
    else $error("cpu_ready or wb_cyc high after reset");

endmodule

bind cache_controller cache_assertions cache_assertions_inst (
  .clk      (clk),
  .rst      (rst),
  .state    (state),
  .cpu_ready(cpu_ready),
  .wb_cyc   (wb_cyc),
  .wb_stb   (wb_stb),
  .wb_we    (wb_we),
  .wb_adr   (wb_adr),
  .wb_dat_w (wb_dat_w),
  .wb_ack   (wb_ack)
);

// ==== rtl/cache_subsystem.sv ====
//##########################################################
// cache top: controller, tag and data arrays, backing memory;
// processor request/ready port is the only external interface
//##########################################################
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_subsystem (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 cpu_valid,
  input  logic                 cpu_we,
  input  bus_types_pkg::addr_t cpu_addr,
  input  bus_types_pkg::word_t cpu_wdata,
  output logic                 cpu_ready,
  output bus_types_pkg::word_t cpu_rdata
);

  // storage ports
  logic [`CACHE_INDEX_BITS-1:0] tag_index;
  logic                         tag_we;
  cache_types_pkg::cache_tag_t  tag_wdata;
  cache_types_pkg::cache_tag_t  tag_rdata;
  logic [`CACHE_INDEX_BITS-1:0] data_index;
  logic                         data_we;
  cache_types_pkg::cache_line_t data_wdata;
  cache_types_pkg::cache_line_t data_rdata;

  // wishbone
  logic                 wb_cyc;
  logic                 wb_stb;
  logic                 wb_we;
  bus_types_pkg::addr_t wb_adr;
  bus_types_pkg::word_t wb_dat_w;
  bus_types_pkg::word_t wb_dat_r;
  logic                 wb_ack;

  cache_controller cache_controller_inst (.*);

  cache_line_ram #(
    .payload_t(cache_types_pkg::cache_tag_t)
  ) tag_ram (
    .clk  (clk),
    .rst  (rst),
    .index(tag_index),
    .we   (tag_we),
    .wdata(tag_wdata),
    .rdata(tag_rdata)
  );

  cache_line_ram #(
    .payload_t(cache_types_pkg::cache_line_t)
  ) data_ram (
    .clk  (clk),
    .rst  (rst),
    .index(data_index),
    .we   (data_we),
    .wdata(data_wdata),
    .rdata(data_rdata)
  );

  main_memory main_memory_inst (.*);

endmodule

// ==== rtl/main_memory.sv ====
//##########################################################
// word memory as wishbone classic slave, fixed wait states;
// contents start as address xor a constant and reset restores it
//##########################################################
`timescale 1ns/1ps
`include "cache_params.svh"

module main_memory (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 wb_cyc,
  input  logic                 wb_stb,
  input  logic                 wb_we,
  input  bus_types_pkg::addr_t wb_adr,
  input  bus_types_pkg::word_t wb_dat_w,
  output bus_types_pkg::word_t wb_dat_r,
  output logic                 wb_ack
);

  localparam int WAIT_W = $clog2(`MEM_WAIT_CYCLES + 2);

  bus_types_pkg::word_t mem [`MEM_WORDS];
  logic [WAIT_W-1:0]    wait_cnt;  // cycles a strobe has been pending
  logic                 req;

  assign req = wb_cyc && wb_stb && !wb_ack;  // ack cycle is not a new request

  // ack after the wait states, held one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_ack   <= 1'b0;
      wait_cnt <= '0;
    end else begin
      wb_ack <= 1'b0;
      if (req) begin
        if (wait_cnt == WAIT_W'(`MEM_WAIT_CYCLES)) begin
          wb_ack   <= 1'b1;
          wait_cnt <= '0;
        end else begin
          wait_cnt <= wait_cnt + 1'b1;
        end
      end else begin
        wait_cnt <= '0;  // strobe dropped or acked
      end
    end
  end

  // read data registered so it is valid with ack
  always_ff @(posedge clk) begin
    if (req) begin
      wb_dat_r <= mem[wb_adr];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `MEM_WORDS; i++) begin
        mem[i] <= bus_types_pkg::word_t'(i) ^ `MEM_INIT_XOR;  // known pattern
      end
    end else if (wb_ack && wb_we) begin
      mem[wb_adr] <= wb_dat_w;  // master still holds fields here
    end
  end

endmodule

// ==== rtl/cache_controller.sv ====
//##########################################################
// direct-mapped write-back cache FSM; answers processor hits,
// masters wishbone for victim write-back and line refill
//##########################################################
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_controller (
  input  logic                         clk,
  input  logic                         rst,
  // processor port
  input  logic                         cpu_valid,
  input  logic                         cpu_we,
  input  bus_types_pkg::addr_t         cpu_addr,
  input  bus_types_pkg::word_t         cpu_wdata,
  output logic                         cpu_ready,
  output bus_types_pkg::word_t         cpu_rdata,
  // tag storage
  output logic [`CACHE_INDEX_BITS-1:0] tag_index,
  output logic                         tag_we,
  output cache_types_pkg::cache_tag_t  tag_wdata,
  input  cache_types_pkg::cache_tag_t  tag_rdata,
  // data storage
  output logic [`CACHE_INDEX_BITS-1:0] data_index,
  output logic                         data_we,
  output cache_types_pkg::cache_line_t data_wdata,
  input  cache_types_pkg::cache_line_t data_rdata,
  // wishbone classic master
  output logic                         wb_cyc,
  output logic                         wb_stb,
  output logic                         wb_we,
  output bus_types_pkg::addr_t         wb_adr,
  output bus_types_pkg::word_t         wb_dat_w,
  input  bus_types_pkg::word_t         wb_dat_r,
  input  logic                         wb_ack
);

  cache_types_pkg::ctrl_state_t  state;       // current state
  cache_types_pkg::ctrl_state_t  next_state;
  logic [`CACHE_OFFSET_BITS-1:0] beat;        // word within line transfer
  cache_types_pkg::cache_line_t  line_buf;    // refill words collected so far

  logic [`CACHE_TAG_BITS-1:0]    cpu_tag;
  logic [`CACHE_INDEX_BITS-1:0]  cpu_index;
  logic [`CACHE_OFFSET_BITS-1:0] cpu_offset;
  logic                          hit;
  logic                          victim_dirty;
  logic                          last_beat;
  logic                          beat_done;
  cache_types_pkg::cache_line_t  merged_line;  // stored line with cpu word put in
  cache_types_pkg::cache_line_t  refill_line;  // buffer plus word on the bus

  // address split: tag | index | offset
  assign cpu_tag    = cpu_addr[`CACHE_ADDR_BITS-1 -: `CACHE_TAG_BITS];
  assign cpu_index  = cpu_addr[`CACHE_OFFSET_BITS +: `CACHE_INDEX_BITS];
  assign cpu_offset = cpu_addr[`CACHE_OFFSET_BITS-1:0];

  // request is held, so both arrays stay on its line throughout
  assign tag_index  = cpu_index;
  assign data_index = cpu_index;

  assign hit          = tag_rdata.valid && (tag_rdata.tag == cpu_tag);
  assign victim_dirty = tag_rdata.valid && tag_rdata.dirty;  // must go out first
  assign last_beat    = (beat == '1);
  assign beat_done    = wb_stb && wb_ack;

  assign cpu_rdata = data_rdata[cpu_offset];  // word select for reads

  always_comb begin
    merged_line             = data_rdata;
    merged_line[cpu_offset] = cpu_wdata;  // write hit modifies one word
  end

  always_comb begin
    refill_line       = line_buf;
    refill_line[beat] = wb_dat_r;  // last word goes straight in
  end

  always_comb begin
    next_state = state;
    cpu_ready  = 1'b0;
    tag_we     = 1'b0;
    data_we    = 1'b0;
    tag_wdata  = '{valid: 1'b1, dirty: 1'b0, tag: cpu_tag};
    data_wdata = merged_line;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = {cpu_tag, cpu_index, beat};  // refill address
    wb_dat_w   = data_rdata[beat];

    case (state)
      cache_types_pkg::idle: begin
        if (cpu_valid) begin
          next_state = cache_types_pkg::compare_tag;
        end
      end

      cache_types_pkg::compare_tag: begin
        if (hit) begin
          cpu_ready  = 1'b1;  // one cycle per request
          next_state = cache_types_pkg::idle;
          if (cpu_we) begin
            data_we         = 1'b1;
            tag_we          = 1'b1;
            tag_wdata.dirty = 1'b1;  // line now newer than memory
          end
        end else if (victim_dirty) begin
          next_state = cache_types_pkg::write_back;
        end else begin
          next_state = cache_types_pkg::allocate;  // cold or clean victim
        end
      end

      cache_types_pkg::write_back: begin
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b1;
        wb_adr = {tag_rdata.tag, cpu_index, beat};  // victim address
        if (beat_done && last_beat) begin
          next_state = cache_types_pkg::allocate;
        end
      end

      cache_types_pkg::allocate: begin
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        if (beat_done && last_beat) begin
          // line and clean tag land together, recompare then hits
          data_we    = 1'b1;
          data_wdata = refill_line;
          tag_we     = 1'b1;
          next_state = cache_types_pkg::compare_tag;
        end
      end

      default: begin
        next_state = cache_types_pkg::idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= cache_types_pkg::idle;
      beat  <= '0;
    end else begin
      state <= next_state;
      if (state == cache_types_pkg::compare_tag) begin
        beat <= '0;  // every transfer starts at word 0
      end else if (beat_done) begin
        beat <= beat + 1'b1;  // wraps to 0 after word 3
      end
    end
  end

  // refill capture
  always_ff @(posedge clk) begin
    if (state == cache_types_pkg::allocate && beat_done) begin
      line_buf[beat] <= wb_dat_r;
    end
  end

endmodule

// ==== rtl/cache_line_ram.sv ====
//##########################################################
// small indexed store, async read, clocked write;
// payload_t picks what is stored (tag entries or data lines)
//##########################################################
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_line_ram #(
  parameter type payload_t = logic [7:0]
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [`CACHE_INDEX_BITS-1:0] index,
  input  logic                         we,
  input  payload_t                     wdata,
  output payload_t                     rdata
);

  payload_t mem [`CACHE_LINES];  // one entry per cache line

  assign rdata = mem[index];  // combinational lookup

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `CACHE_LINES; i++) begin
        mem[i] <= '0;  // zero tag is invalid
      end
    end else if (we) begin
      mem[index] <= wdata;  // visible to next read
    end
  end

endmodule

// ==== rtl/cache_types_pkg.sv ====
//##########################################################
// cache-internal types: tag entry, line and controller state
//##########################################################
package cache_types_pkg;

  // one tag entry, reset value of all zeros means invalid
  typedef struct packed {
    logic       valid;  // line holds memory data
    logic       dirty;  // line differs from memory
    logic [6:0] tag;    // address bits 11..5
  } cache_tag_t;

  // four words per line, word 0 in the low bits
  typedef bus_types_pkg::word_t [3:0] cache_line_t;

  // controller flow, same four states as the classic write-back FSM
  typedef enum logic [1:0] {
    idle,         // waiting for a processor request
    compare_tag,  // lookup, answer on hit
    write_back,   // dirty victim going out to memory
    allocate      // new line coming in from memory
  } ctrl_state_t;

endpackage

// ==== rtl/bus_types_pkg.sv ====
//##########################################################
// address and data word types shared by processor port,
// wishbone bus and backing memory
//##########################################################
package bus_types_pkg;

  // word addressed, 4096 words of memory
  localparam int ADDR_BITS = 12;

  // one data word on every port
  localparam int WORD_BITS = 16;

  // word address
  typedef logic [ADDR_BITS-1:0] addr_t;

  // data word
  typedef logic [WORD_BITS-1:0] word_t;

endpackage

// ==== rtl/cache_params.svh ====
//##########################################################
// size and timing constants of the cache subsystem,
// included by every RTL file that slices addresses or sizes arrays
//##########################################################
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// word address into backing memory
`define CACHE_ADDR_BITS 12

// 8 lines of 4 words
`define CACHE_INDEX_BITS 3
`define CACHE_OFFSET_BITS 2
`define CACHE_TAG_BITS (`CACHE_ADDR_BITS - `CACHE_INDEX_BITS - `CACHE_OFFSET_BITS)

`define CACHE_LINES (1 << `CACHE_INDEX_BITS)  // entries per storage array
`define MEM_WORDS (1 << `CACHE_ADDR_BITS)     // backing memory depth

// memory behaviour
`define MEM_WAIT_CYCLES 2     // idle cycles before each ack
`define MEM_INIT_XOR 16'h5a00 // mixed into address for initial contents

`endif
